// File: sim.f
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_ctrl_pkg.sv
logic/circular_buffer.sv
logic/input_buffer.sv
logic/vc_allocator.sv
logic/switch_arbiter.sv
logic/input_port.sv
verif/input_port_tb.sv

// File: Bender.yml
package:
  name: noc_input_port

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/noc_flit_pkg.sv
      - logic/noc_ctrl_pkg.sv
      - logic/circular_buffer.sv
      - logic/input_buffer.sv
      - logic/vc_allocator.sv
      - logic/switch_arbiter.sv
      - logic/input_port.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/input_port_tb.sv

// File: verif/input_port_tb.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module input_port_tb;

    // About 16 reset cycles and six tests of under 60 cycles each, with wide margin.
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int QUIET_CYCLES   = 8;
    localparam int LFSR_SEED      = 99661;

    logic                   clk;
    logic                   rst;
    noc_flit_pkg::flit_t    flit_i;
    logic                   write_i;
    noc_flit_pkg::port_t    out_port_i;
    logic                   downstream_on_i;
    noc_flit_pkg::flit_t    flit_o;
    logic                   flit_valid_o;
    noc_flit_pkg::port_t    out_port_o;
    logic [`NOC_VC_NUM-1:0] on_off_o;

    // Expected and received flits, vc_id already downstream.
    noc_flit_pkg::flit_t exp_flits [$];
    noc_flit_pkg::port_t exp_ports [$];
    noc_flit_pkg::flit_t rx_flits [$];
    noc_flit_pkg::port_t rx_ports [$];

    // Taps 17 and 14.
    logic [16:0] lfsr_q;
    int          cycle_count;
    int          error_count;

    input_port u_dut (
        .clk             (clk),
        .rst             (rst),
        .flit_i          (flit_i),
        .write_i         (write_i),
        .out_port_i      (out_port_i),
        .downstream_on_i (downstream_on_i),
        .flit_o          (flit_o),
        .flit_valid_o    (flit_valid_o),
        .out_port_o      (out_port_o),
        .on_off_o        (on_off_o)
    );

    // ########################################################################
    // Clock, monitor and timeout
    // ########################################################################

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Outputs are registered, stable at the falling edge.
    always @(negedge clk)
    begin
        if (!rst && flit_valid_o)
        begin
            rx_flits.push_back(flit_o);
            rx_ports.push_back(out_port_o);
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ########################################################################
    // Helpers
    // ########################################################################

    // One bit per step.
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_q[16];
        lfsr_q  = {lfsr_q[15:0], lfsr_q[16] ^ lfsr_q[13]};
        return out_bit;
    endfunction

    function automatic logic [`NOC_DATA_W-1:0] random_data();
        logic [`NOC_DATA_W-1:0] value;
        value = '0;
        for (int i = 0; i < `NOC_DATA_W; i++)
            value = {value[`NOC_DATA_W-2:0], lfsr_bit()};
        return value;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            error_count = error_count + 1;
            $display("** Error at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    // Inputs change 1 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Writes one flit; a delivered flit is also queued as expected output.
    task automatic send_flit(input int vc, input noc_flit_pkg::flit_label_t label,
                             input noc_flit_pkg::port_t port,
                             input logic [`NOC_VC_W-1:0] down_vc, input logic delivered);
        noc_flit_pkg::flit_t flit;
        flit.flit_label = label;
        flit.vc_id      = `NOC_VC_W'(vc);
        flit.data       = random_data();
        flit_i          = flit;
        out_port_i      = port;
        write_i         = 1'b1;
        if (delivered)
        begin
            flit.vc_id = down_vc;
            exp_flits.push_back(flit);
            exp_ports.push_back(port);
        end
        step();
        write_i = 1'b0;
    endtask

    // First pending flit on the same downstream channel must match.
    task automatic match_output(input noc_flit_pkg::flit_t got,
                                input noc_flit_pkg::port_t got_port);
        int pos;
        pos = -1;
        foreach (exp_flits[i])
            if (pos < 0 && exp_flits[i].vc_id == got.vc_id)
                pos = i;
        check_equal(pos >= 0, 1, "output flit on a channel with nothing pending");
        check_equal(got, exp_flits[pos], "output flit");
        check_equal(got_port, exp_ports[pos], "output port");
        exp_flits.delete(pos);
        exp_ports.delete(pos);
    endtask

    task automatic drain_outputs();
        noc_flit_pkg::flit_t got;
        noc_flit_pkg::port_t got_port;
        while (exp_flits.size() > 0)
        begin
            if (rx_flits.size() > 0)
            begin
                got      = rx_flits.pop_front();
                got_port = rx_ports.pop_front();
                match_output(got, got_port);
            end
            else
            begin
                step();
            end
        end
        // Also lets the tails release their downstream channels.
        repeat (QUIET_CYCLES) step();
        check_equal(rx_flits.size(), 0, "extra output flits");
    endtask

    // ########################################################################
    // Directed tests
    // ########################################################################

    task automatic check_reset_state();
        check_equal(flit_valid_o, 1'b0, "flit_valid_o after reset");
        check_equal(on_off_o, {`NOC_VC_NUM{1'b1}}, "on_off_o after reset");
        check_equal(out_port_o, noc_flit_pkg::LOCAL, "out_port_o after reset");
    endtask

    task automatic send_one_packet();
        send_flit(0, noc_flit_pkg::HEAD, noc_flit_pkg::EAST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::EAST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::EAST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::TAIL, noc_flit_pkg::EAST, 0, 1'b1);
        drain_outputs();
    endtask

    // Channel 0 takes downstream 0 first, channel 1 gets 1.
    task automatic interleave_two_channels();
        send_flit(0, noc_flit_pkg::HEAD, noc_flit_pkg::SOUTH, 0, 1'b1);
        send_flit(1, noc_flit_pkg::HEAD, noc_flit_pkg::NORTH, 1, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::SOUTH, 0, 1'b1);
        send_flit(1, noc_flit_pkg::BODY, noc_flit_pkg::NORTH, 1, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::SOUTH, 0, 1'b1);
        send_flit(1, noc_flit_pkg::TAIL, noc_flit_pkg::NORTH, 1, 1'b1);
        send_flit(0, noc_flit_pkg::TAIL, noc_flit_pkg::SOUTH, 0, 1'b1);
        drain_outputs();
    endtask

    task automatic hold_back_pressure();
        downstream_on_i = 1'b0;
        send_flit(1, noc_flit_pkg::HEAD, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(1, noc_flit_pkg::BODY, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(1, noc_flit_pkg::TAIL, noc_flit_pkg::WEST, 0, 1'b1);
        // Three stored flits reach the threshold.
        check_equal(on_off_o, 2'b01, "on_off_o under back-pressure");
        repeat (10)
        begin
            step();
            check_equal(flit_valid_o, 1'b0, "flit_valid_o under back-pressure");
        end
        downstream_on_i = 1'b1;
        drain_outputs();
        check_equal(on_off_o, 2'b11, "on_off_o after back-pressure");
    endtask

    // Extra head inside a packet and a body after the tail are dropped.
    task automatic drop_stray_flits();
        send_flit(0, noc_flit_pkg::HEAD, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::HEAD, noc_flit_pkg::WEST, 0, 1'b0);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::TAIL, noc_flit_pkg::WEST, 0, 1'b1);
        send_flit(0, noc_flit_pkg::BODY, noc_flit_pkg::WEST, 0, 1'b0);
        drain_outputs();
    endtask

    // Channel 1 held downstream 1 before, both are free again.
    task automatic reuse_released_vc();
        send_flit(1, noc_flit_pkg::HEAD, noc_flit_pkg::NORTH, 0, 1'b1);
        send_flit(1, noc_flit_pkg::BODY, noc_flit_pkg::NORTH, 0, 1'b1);
        send_flit(1, noc_flit_pkg::TAIL, noc_flit_pkg::NORTH, 0, 1'b1);
        drain_outputs();
    endtask

    // ########################################################################
    // Sequence
    // ########################################################################

    initial
    begin
        rst             = 1'b1;
        flit_i          = '0;
        write_i         = 1'b0;
        out_port_i      = noc_flit_pkg::LOCAL;
        downstream_on_i = 1'b1;
        lfsr_q          = 17'(LFSR_SEED);
        cycle_count     = 0;
        error_count     = 0;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_state();
        send_one_packet();
        interleave_two_channels();
        hold_back_pressure();
        drop_stray_flits();
        reuse_released_vc();

        if (error_count == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("SIMULATION FAILED");
            $fatal(1, "Checks failed");
        end
    end

endmodule

// File: logic/input_port.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module input_port (
    input  logic                   clk,
    input  logic                   rst,
    input  noc_flit_pkg::flit_t    flit_i,
    input  logic                   write_i,
    input  noc_flit_pkg::port_t    out_port_i,
    input  logic                   downstream_on_i,
    output noc_flit_pkg::flit_t    flit_o,
    output logic                   flit_valid_o,
    output noc_flit_pkg::port_t    out_port_o,
    output logic [`NOC_VC_NUM-1:0] on_off_o
);

    noc_ctrl_pkg::vc_status_t status [`NOC_VC_NUM];
    logic [`NOC_VC_NUM-1:0]   vc_valid;
    logic [`NOC_VC_W-1:0]     vc_new [`NOC_VC_NUM];
    logic [`NOC_VC_NUM-1:0]   read;

    // #########################################################################
    // Channel buffers
    // #########################################################################

    for (genvar i = 0; i < `NOC_VC_NUM; i++)
    begin : g_vc
        // Write goes to the channel named by the flit.
        // Front flit reaches the arbiter through status.
        input_buffer #(
            .BUFFER_SIZE    (`NOC_BUFFER_SIZE),
            .PIPELINE_DEPTH (`NOC_PIPELINE_DEPTH)
        ) u_input_buffer (
            .clk        (clk),
            .rst        (rst),
            .data_i     (flit_i),
            .write_i    (write_i && flit_i.vc_id == `NOC_VC_W'(i)),
            .read_i     (read[i]),
            .out_port_i (out_port_i),
            .vc_valid_i (vc_valid[i]),
            .vc_new_i   (vc_new[i]),
            .data_o     (),
            .status_o   (status[i]),
            .on_off_o   (on_off_o[i])
        );
    end

    // #########################################################################
    // Allocation
    // #########################################################################

    vc_allocator u_vc_allocator (
        .clk        (clk),
        .rst        (rst),
        .status_i   (status),
        .vc_valid_o (vc_valid),
        .vc_new_o   (vc_new)
    );

    switch_arbiter u_switch_arbiter (
        .clk             (clk),
        .rst             (rst),
        .status_i        (status),
        .downstream_on_i (downstream_on_i),
        .read_o          (read),
        .flit_o          (flit_o),
        .flit_valid_o    (flit_valid_o),
        .out_port_o      (out_port_o)
    );

endmodule

// File: logic/switch_arbiter.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module switch_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_ctrl_pkg::vc_status_t status_i [`NOC_VC_NUM],
    input  logic                     downstream_on_i,
    output logic [`NOC_VC_NUM-1:0]   read_o,
    output noc_flit_pkg::flit_t      flit_o,
    output logic                     flit_valid_o,
    output noc_flit_pkg::port_t      out_port_o
);

    noc_ctrl_pkg::sa_grant_t grant;
    logic [`NOC_VC_NUM-1:0]  eligible;
    // Previous winner.
    logic [`NOC_VC_W-1:0]    last;

    // #########################################################################
    // Round-robin grant
    // #########################################################################

    always_comb
    begin
        int idx;

        // Holding a downstream channel and a flit to send.
        for (int i = 0; i < `NOC_VC_NUM; i++)
            eligible[i] = !status_i[i].is_empty && !status_i[i].vc_request;

        grant = '0;
        for (int k = 1; k <= `NOC_VC_NUM; k++)
        begin
            idx = (int'(last) + k) % `NOC_VC_NUM;
            // Back-pressure blocks every grant.
            if (downstream_on_i && !grant.valid && eligible[idx])
            begin
                grant.valid = 1'b1;
                grant.idx   = idx[`NOC_VC_W-1:0];
            end
        end

        read_o = '0;
        if (grant.valid)
            read_o[grant.idx] = 1'b1;
    end

    // #########################################################################
    // Output register
    // #########################################################################

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            flit_valid_o <= 1'b0;
            out_port_o   <= noc_flit_pkg::LOCAL;
            last         <= '1;
        end
        else
        begin
            flit_valid_o <= grant.valid;
            if (grant.valid)
            begin
                last       <= grant.idx;
                out_port_o <= status_i[grant.idx].out_port;
            end
        end
    end

    // Flit payload.
    always_ff @(posedge clk)
    begin
        if (grant.valid)
            flit_o <= status_i[grant.idx].front_flit;
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(read_o));

endmodule

// File: logic/vc_allocator.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module vc_allocator (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_ctrl_pkg::vc_status_t status_i [`NOC_VC_NUM],
    output logic [`NOC_VC_NUM-1:0]   vc_valid_o,
    output logic [`NOC_VC_W-1:0]     vc_new_o [`NOC_VC_NUM]
);

    // Per downstream channel.
    logic [`NOC_VC_NUM-1:0] free;
    logic [`NOC_VC_W-1:0]   owner [`NOC_VC_NUM];
    // Last requester served.
    logic [`NOC_VC_W-1:0]   rr_ptr;

    logic [`NOC_VC_NUM-1:0] req;
    logic                   grant_valid;
    logic [`NOC_VC_W-1:0]   grant_in;
    logic [`NOC_VC_W-1:0]   grant_vc;

    // #########################################################################
    // Choice of requester and channel
    // #########################################################################

    always_comb
    begin
        int  idx;
        logic req_found;
        logic vc_found;

        // A pending grant is still visible as a request.
        for (int i = 0; i < `NOC_VC_NUM; i++)
            req[i] = status_i[i].vc_request && !vc_valid_o[i];

        // Lowest free downstream channel wins.
        vc_found = 1'b0;
        grant_vc = '0;
        for (int d = `NOC_VC_NUM - 1; d >= 0; d--)
        begin
            if (free[d])
            begin
                vc_found = 1'b1;
                grant_vc = d[`NOC_VC_W-1:0];
            end
        end

        // Search starts after the last winner.
        req_found = 1'b0;
        grant_in  = rr_ptr;
        for (int k = 1; k <= `NOC_VC_NUM; k++)
        begin
            idx = (int'(rr_ptr) + k) % `NOC_VC_NUM;
            if (!req_found && req[idx])
            begin
                req_found = 1'b1;
                grant_in  = idx[`NOC_VC_W-1:0];
            end
        end

        grant_valid = req_found && vc_found;
    end

    // #########################################################################
    // Ownership
    // #########################################################################

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            free       <= '1;
            vc_valid_o <= '0;
            rr_ptr     <= '1;
        end
        else
        begin
            // Release by the owner's tail.
            for (int d = 0; d < `NOC_VC_NUM; d++)
                for (int i = 0; i < `NOC_VC_NUM; i++)
                    if (status_i[i].vc_allocatable && !free[d] &&
                        owner[d] == i[`NOC_VC_W-1:0])
                        free[d] <= 1'b1;
            vc_valid_o <= '0;
            if (grant_valid)
            begin
                free[grant_vc]       <= 1'b0;
                vc_valid_o[grant_in] <= 1'b1;
                rr_ptr               <= grant_in;
            end
        end
    end

    // Channel id and owner, qualified by vc_valid_o and free.
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            owner[grant_vc]    <= grant_in;
            vc_new_o[grant_in] <= grant_vc;
        end
    end

    // A granted channel stays owned, never handed out on the next cycle.
    assert property (@(posedge clk) disable iff (rst)
        grant_valid |=> !(grant_valid && grant_vc == $past(grant_vc)));

endmodule

// File: logic/input_buffer.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module input_buffer #(
    parameter int BUFFER_SIZE    = `NOC_BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = `NOC_PIPELINE_DEPTH
)(
    input  logic                     clk,
    input  logic                     rst,
    input  noc_flit_pkg::flit_t      data_i,
    input  logic                     write_i,
    input  logic                     read_i,
    input  noc_flit_pkg::port_t      out_port_i,
    input  logic                     vc_valid_i,
    input  logic [`NOC_VC_W-1:0]     vc_new_i,
    output noc_flit_pkg::flit_t      data_o,
    output noc_ctrl_pkg::vc_status_t status_o,
    output logic                     on_off_o
);

    typedef enum logic [1:0]
    {
        IDLE,
        VA,
        SA
    } state_t;

    state_t state;
    state_t state_next;

    noc_flit_pkg::flit_t  read_flit;
    noc_flit_pkg::port_t  out_port;
    noc_flit_pkg::port_t  out_port_next;
    logic [`NOC_VC_W-1:0] downstream_vc;
    logic [`NOC_VC_W-1:0] downstream_vc_next;

    logic write_cmd;
    logic read_cmd;
    logic is_full;
    logic is_empty;
    // Tail already stored, later flits are dropped.
    logic end_packet;
    logic end_packet_next;
    logic vc_allocatable;
    logic vc_allocatable_next;
    // Body or tail offered while the packet is still open.
    logic write_body;

    circular_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_circular_buffer (
        .clk        (clk),
        .rst        (rst),
        .data_i     (data_i),
        .read_i     (read_cmd),
        .write_i    (write_cmd),
        .data_o     (read_flit),
        .is_full_o  (is_full),
        .is_empty_o (is_empty),
        .on_off_o   (on_off_o)
    );

    // #########################################################################
    // State registers
    // #########################################################################

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state          <= IDLE;
            out_port       <= noc_flit_pkg::LOCAL;
            downstream_vc  <= '0;
            end_packet     <= 1'b0;
            vc_allocatable <= 1'b0;
        end
        else
        begin
            state          <= state_next;
            out_port       <= out_port_next;
            downstream_vc  <= downstream_vc_next;
            end_packet     <= end_packet_next;
            vc_allocatable <= vc_allocatable_next;
        end
    end

    // #########################################################################
    // Packet FSM and write rule
    // #########################################################################

    assign write_body = write_i && !is_full && !end_packet &&
                        (data_i.flit_label == noc_flit_pkg::BODY ||
                         data_i.flit_label == noc_flit_pkg::TAIL);

    always_comb
    begin
        state_next          = state;
        out_port_next       = out_port;
        downstream_vc_next  = downstream_vc;
        end_packet_next     = end_packet;
        vc_allocatable_next = 1'b0;
        write_cmd           = 1'b0;
        read_cmd            = 1'b0;

        unique case (state)
            IDLE:
            begin
                // Head opens a packet, route comes with it.
                if (write_i && is_empty && data_i.flit_label == noc_flit_pkg::HEAD)
                begin
                    state_next    = VA;
                    out_port_next = out_port_i;
                    write_cmd     = 1'b1;
                end
            end
            VA:
            begin
                if (vc_valid_i)
                begin
                    state_next         = SA;
                    downstream_vc_next = vc_new_i;
                end
                write_cmd = write_body;
            end
            SA:
            begin
                write_cmd = write_body;
                read_cmd  = read_i;
                // Tail leaving closes the packet.
                if (read_i && data_o.flit_label == noc_flit_pkg::TAIL)
                begin
                    state_next          = IDLE;
                    end_packet_next     = 1'b0;
                    vc_allocatable_next = 1'b1;
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase

        if (write_body && data_i.flit_label == noc_flit_pkg::TAIL && state != IDLE)
            end_packet_next = 1'b1;
    end

    // #########################################################################
    // Outgoing flit and status
    // #########################################################################

    // Downstream channel replaces the upstream one.
    always_comb
    begin
        data_o       = read_flit;
        data_o.vc_id = downstream_vc;
    end

    assign status_o.front_flit     = data_o;
    assign status_o.out_port       = out_port;
    assign status_o.is_empty       = is_empty;
    assign status_o.vc_request     = (state == VA);
    assign status_o.vc_allocatable = vc_allocatable;

    // Allocator answers only an open request.
    assert property (@(posedge clk) disable iff (rst) vc_valid_i |-> state == VA);

endmodule

// File: logic/circular_buffer.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module circular_buffer #(
    parameter int BUFFER_SIZE    = `NOC_BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = `NOC_PIPELINE_DEPTH
)(
    input  logic                clk,
    input  logic                rst,
    input  noc_flit_pkg::flit_t data_i,
    input  logic                read_i,
    input  logic                write_i,
    output noc_flit_pkg::flit_t data_o,
    output logic                is_full_o,
    output logic                is_empty_o,
    output logic                on_off_o
);

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    // Flit storage.
    noc_flit_pkg::flit_t mem [BUFFER_SIZE];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // #########################################################################
    // Storage and pointers
    // #########################################################################

    // Payload only.
    always_ff @(posedge clk)
    begin
        if (write_i)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Pointers wrap at the last slot.
            if (write_i)
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            if (read_i)
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous read and write leave the count alone.
            if (write_i && !read_i)
                count <= count + 1'b1;
            else if (read_i && !write_i)
                count <= count - 1'b1;
        end
    end

    // #########################################################################
    // Flags
    // #########################################################################

    // Front of the queue, no read latency.
    assign data_o     = mem[rd_ptr];
    assign is_full_o  = (count == CNT_W'(BUFFER_SIZE));
    assign is_empty_o = (count == '0);
    // Upstream must stop while the in-flight flits still fit.
    assign on_off_o   = (count < CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH));

    // Writer and reader live in other modules.
    assert property (@(posedge clk) disable iff (rst) write_i |-> !is_full_o);
    assert property (@(posedge clk) disable iff (rst) read_i |-> !is_empty_o);

endmodule

// File: logic/noc_ctrl_pkg.sv
`include "noc_macros.svh"

package noc_ctrl_pkg;

    // #########################################################################
    // Port control
    // #########################################################################

    // What one input channel shows the allocators.
    typedef struct packed
    {
        // Front flit, vc_id already rewritten.
        noc_flit_pkg::flit_t    front_flit;
        // Route latched from the head.
        noc_flit_pkg::port_t    out_port;
        logic                   is_empty;
        // High for the whole VA state.
        logic                   vc_request;
        // One-cycle pulse after the tail leaves.
        logic                   vc_allocatable;
    } vc_status_t;

    // Switch arbiter decision for one cycle.
    typedef struct packed
    {
        logic                   valid;
        logic [`NOC_VC_W-1:0]   idx;
    } sa_grant_t;

endpackage

// File: logic/noc_flit_pkg.sv
`include "noc_macros.svh"

package noc_flit_pkg;

    // #########################################################################
    // Flit format
    // #########################################################################

    // Flit kind.
    // A single-flit packet is not supported.
    typedef enum logic [1:0]
    {
        HEAD,
        BODY,
        TAIL
    } flit_label_t;

    // One flit on the link.
    // Label, channel id, then payload, 19 bits.
    typedef struct packed
    {
        flit_label_t               flit_label;
        logic [`NOC_VC_W-1:0]      vc_id;
        logic [`NOC_DATA_W-1:0]    data;
    } flit_t;

    // Output direction of the router.
    typedef enum logic [2:0]
    {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

endpackage

// File: logic/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Virtual channels per port, input and downstream alike.
`define NOC_VC_NUM 2
// Channel identifier width.
`define NOC_VC_W 1

// Flit slots per channel buffer.
`define NOC_BUFFER_SIZE 8
// Flits still in flight upstream after on/off falls.
`define NOC_PIPELINE_DEPTH 5

// Flit payload width.
`define NOC_DATA_W 16

`endif
